// ==== rtl/dmaFifo_defs.svh ====
`ifndef DMAFIFO_DEFS_SVH
`define DMAFIFO_DEFS_SVH

// number of entries in the array
// power of two so the pointers wrap on their own
`define FIFO_DEPTH 16

// width of the default payload word
`define FIFO_DATA_WIDTH 32

// almostEmpty is high at or below this count
`define FIFO_AE_THRESHOLD (`FIFO_DEPTH / 4)

// almostFull is high at or above this count
// two slots of slack for the writer
`define FIFO_AF_THRESHOLD (`FIFO_DEPTH - 2)

`endif

// ==== rtl/dmaFifoPkg.sv ====
`default_nettype none

package dmaFifoPkg;

`include "dmaFifo_defs.svh"

   // address bits for one array entry
   localparam int PTR_WIDTH = $clog2(`FIFO_DEPTH);

   // default payload carried by the DMA FIFO
   typedef logic [`FIFO_DATA_WIDTH-1:0] dataWord_t;

   // read or write address into the array
   typedef logic [PTR_WIDTH-1:0] ptr_t;

   // entry count, one extra bit so a full FIFO fits
   typedef logic [PTR_WIDTH:0] count_t;

endpackage

`default_nettype wire

// ==== rtl/fifoControl.sv ====
`default_nettype none

`include "dmaFifo_defs.svh"

module fifoControl (
   input  logic              clkin,
   input  logic              reset_n,
   input  logic              syncReset_n,
   input  logic              wrEn,
   input  logic              rdEn,
   output dmaFifoPkg::ptr_t  wrPtr,
   output dmaFifoPkg::ptr_t  rdPtr,
   output logic              memWrite,
   output logic              headFromInput,
   output logic              headFromMem,
   output logic              clearHead,
   output logic              empty,
   output logic              almostEmpty,
   output logic              full,
   output logic              almostFull
);

   // flag limits in the width of the count
   localparam dmaFifoPkg::count_t DEPTH_COUNT = dmaFifoPkg::count_t'(`FIFO_DEPTH);
   localparam dmaFifoPkg::count_t AE_COUNT = dmaFifoPkg::count_t'(`FIFO_AE_THRESHOLD);
   localparam dmaFifoPkg::count_t AF_COUNT = dmaFifoPkg::count_t'(`FIFO_AF_THRESHOLD);

   dmaFifoPkg::count_t entryCount;
   dmaFifoPkg::count_t nextCount;
   logic               countIsZero;
   logic               countIsOne;
   logic               advanceRd;

   assign countIsZero = (entryCount == '0);
   assign countIsOne = (entryCount == dmaFifoPkg::count_t'(1));

   // the in-band clear also wipes the head word in storage
   assign clearHead = ~syncReset_n;

   // array write follows the strobe
   // a clear in the same cycle drops the word
   assign memWrite = wrEn & syncReset_n;

   // bypass into the head
   // either nothing is queued, or the only word leaves this cycle
   assign headFromInput = wrEn & (countIsZero | (rdEn & countIsOne));

   // otherwise refill the head from the array on a pop
   // an empty FIFO keeps sampling the array at rdPtr
   assign headFromMem = ~headFromInput & (rdEn | countIsZero);

   // rdPtr always names the word behind the head
   // it moves whenever a word leaves the array for the head
   always_comb begin
      advanceRd = 1'b0;
      if (rdEn && (entryCount > dmaFifoPkg::count_t'(1))) begin
         advanceRd = 1'b1;
      end else if (wrEn && countIsZero) begin
         advanceRd = 1'b1;
      end else if (rdEn && wrEn && countIsOne) begin
         advanceRd = 1'b1;
      end
   end

   // count after this edge
   // clear wins over both strobes
   always_comb begin
      nextCount = entryCount;
      if (!syncReset_n) begin
         nextCount = '0;
      end else begin
         case ({wrEn, rdEn})
            2'b10: nextCount = entryCount + dmaFifoPkg::count_t'(1);
            2'b01: nextCount = entryCount - dmaFifoPkg::count_t'(1);
            default: nextCount = entryCount;
         endcase
      end
   end

   // write pointer
   always_ff @(posedge clkin) begin
      if (!reset_n) begin
         wrPtr <= '0;
      end else if (!syncReset_n) begin
         wrPtr <= '0;
      end else if (wrEn) begin
         wrPtr <= wrPtr + dmaFifoPkg::ptr_t'(1);
      end
   end

   // read pointer
   always_ff @(posedge clkin) begin
      if (!reset_n) begin
         rdPtr <= '0;
      end else if (!syncReset_n) begin
         rdPtr <= '0;
      end else if (advanceRd) begin
         rdPtr <= rdPtr + dmaFifoPkg::ptr_t'(1);
      end
   end

   // entry count, head word included
   always_ff @(posedge clkin) begin
      if (!reset_n) begin
         entryCount <= '0;
      end else begin
         entryCount <= nextCount;
      end
   end

   // status flags
   // all four come from the same next count so they never disagree
   always_ff @(posedge clkin) begin
      if (!reset_n) begin
         empty <= 1'b1;
         almostEmpty <= 1'b1;
         full <= 1'b0;
         almostFull <= 1'b0;
      end else begin
         empty <= (nextCount == '0);
         almostEmpty <= (nextCount <= AE_COUNT);
         full <= (nextCount == DEPTH_COUNT);
         almostFull <= (nextCount >= AF_COUNT);
      end
   end

endmodule

`default_nettype wire

// ==== rtl/fifoStorage.sv ====
`default_nettype none

`include "dmaFifo_defs.svh"

module fifoStorage #(
   parameter type payload_t = dmaFifoPkg::dataWord_t
) (
   input  logic             clkin,
   input  logic             reset_n,
   input  logic             memWrite,
   input  logic             headFromInput,
   input  logic             headFromMem,
   input  logic             clearHead,
   input  dmaFifoPkg::ptr_t wrPtr,
   input  dmaFifoPkg::ptr_t rdPtr,
   input  payload_t         dataIn,
   output payload_t         dataOut
);

   // entry array, distributed RAM sized
   payload_t memArray [`FIFO_DEPTH];

   // oldest word, always presented on the output
   payload_t headWord;
   payload_t memRead;

   // asynchronous read of the next word behind the head
   assign memRead = memArray[rdPtr];

   // array write port
   always_ff @(posedge clkin) begin
      if (memWrite) begin
         memArray[wrPtr] <= dataIn;
      end
   end

   // head register
   // source is chosen by the control block, clear first
   always_ff @(posedge clkin) begin
      if (!reset_n) begin
         headWord <= '0;
      end else if (clearHead) begin
         headWord <= '0;
      end else if (headFromInput) begin
         headWord <= dataIn;
      end else if (headFromMem) begin
         headWord <= memRead;
      end
   end

   assign dataOut = headWord;

endmodule

`default_nettype wire

// ==== rtl/dmaFifo.sv ====
`default_nettype none

module dmaFifo #(
   parameter type payload_t = dmaFifoPkg::dataWord_t
) (
   input  logic     clkin,
   input  logic     reset_n,
   input  logic     syncReset_n,
   input  logic     wrEn,
   input  payload_t dataIn,
   input  logic     rdEn,
   output payload_t dataOut,
   output logic     empty,
   output logic     almostEmpty,
   output logic     full,
   output logic     almostFull
);

   // control to storage
   dmaFifoPkg::ptr_t wrPtr;
   dmaFifoPkg::ptr_t rdPtr;
   logic             memWrite;
   logic             headFromInput;
   logic             headFromMem;
   logic             clearHead;

   // pointers, count, flags and head source select
   fifoControl control (
      .clkin         (clkin),
      .reset_n       (reset_n),
      .syncReset_n   (syncReset_n),
      .wrEn          (wrEn),
      .rdEn          (rdEn),
      .wrPtr         (wrPtr),
      .rdPtr         (rdPtr),
      .memWrite      (memWrite),
      .headFromInput (headFromInput),
      .headFromMem   (headFromMem),
      .clearHead     (clearHead),
      .empty         (empty),
      .almostEmpty   (almostEmpty),
      .full          (full),
      .almostFull    (almostFull)
   );

   // array and head word
   // payload type passed straight down
   fifoStorage #(
      .payload_t (payload_t)
   ) storage (
      .clkin         (clkin),
      .reset_n       (reset_n),
      .memWrite      (memWrite),
      .headFromInput (headFromInput),
      .headFromMem   (headFromMem),
      .clearHead     (clearHead),
      .wrPtr         (wrPtr),
      .rdPtr         (rdPtr),
      .dataIn        (dataIn),
      .dataOut       (dataOut)
   );

endmodule

`default_nettype wire

// ==== tb/tbTasks.svh ====
`ifndef TBTASKS_SVH
`define TBTASKS_SVH

// LCG with the numerical recipes constants
function automatic logic [31:0] nextRandom();
   lcgState = lcgState * 32'd1664525 + 32'd1013904223;
   return lcgState;
endfunction

task automatic checkValue(input string testName, input string what,
                          input dmaFifoPkg::dataWord_t expected,
                          input dmaFifoPkg::dataWord_t actual);
   if (actual !== expected) begin
      $display("[FAIL] %s: %s expected %h actual %h", testName, what, expected, actual);
      $display("Checks failed");
      $fatal(1, "stopping at the first mismatch");
   end
endtask

// flags from the model size and the head word when something is queued
task automatic checkState(input string testName);
   int size;
   size = refQueue.size();
   checkValue(testName, "empty", dmaFifoPkg::dataWord_t'(size == 0),
              dmaFifoPkg::dataWord_t'(empty));
   checkValue(testName, "almostEmpty", dmaFifoPkg::dataWord_t'(size <= `FIFO_AE_THRESHOLD),
              dmaFifoPkg::dataWord_t'(almostEmpty));
   checkValue(testName, "full", dmaFifoPkg::dataWord_t'(size == `FIFO_DEPTH),
              dmaFifoPkg::dataWord_t'(full));
   checkValue(testName, "almostFull", dmaFifoPkg::dataWord_t'(size >= `FIFO_AF_THRESHOLD),
              dmaFifoPkg::dataWord_t'(almostFull));
   if (size > 0) begin
      checkValue(testName, "dataOut", refQueue[0], dataOut);
   end
endtask

// one clock with the given strobes
// called and returning on a falling edge
task automatic driveCycle(input logic wr, input logic rd, input dmaFifoPkg::dataWord_t data);
   wrEn = wr;
   rdEn = rd;
   dataIn = data;
   @(posedge clkin);
   if (rd) begin
      void'(refQueue.pop_front());
   end
   if (wr) begin
      refQueue.push_back(data);
   end
   @(negedge clkin);
   wrEn = 1'b0;
   rdEn = 1'b0;
endtask

task automatic fillTo(input string testName, input int target);
   while (refQueue.size() < target) begin
      driveCycle(1'b1, 1'b0, nextRandom());
      checkState(testName);
   end
endtask

task automatic drainAll(input string testName);
   while (refQueue.size() > 0) begin
      checkState(testName);
      driveCycle(1'b0, 1'b1, '0);
      checkState(testName);
   end
endtask

task automatic testAfterReset();
   checkValue("afterReset", "empty", 1, dmaFifoPkg::dataWord_t'(empty));
   checkValue("afterReset", "almostEmpty", 1, dmaFifoPkg::dataWord_t'(almostEmpty));
   checkValue("afterReset", "full", 0, dmaFifoPkg::dataWord_t'(full));
   checkValue("afterReset", "almostFull", 0, dmaFifoPkg::dataWord_t'(almostFull));
   checkValue("afterReset", "dataOut", '0, dataOut);
endtask

task automatic testFallThrough();
   dmaFifoPkg::dataWord_t word;
   word = nextRandom();
   driveCycle(1'b1, 1'b0, word);
   checkValue("fallThrough", "dataOut", word, dataOut);
   checkValue("fallThrough", "empty", 0, dmaFifoPkg::dataWord_t'(empty));
   driveCycle(1'b0, 1'b1, '0);
   checkValue("fallThrough", "empty", 1, dmaFifoPkg::dataWord_t'(empty));
   checkState("fallThrough");
endtask

task automatic testFillDrain();
   fillTo("fillDrain", `FIFO_DEPTH);
   drainAll("fillDrain");
endtask

// read and write together at counts around the thresholds
task automatic testSimultaneous();
   int points[5];
   points[0] = 1;
   points[1] = 2;
   points[2] = `FIFO_AE_THRESHOLD;
   points[3] = `FIFO_AF_THRESHOLD;
   points[4] = `FIFO_DEPTH - 1;
   for (int p = 0; p < 5; p++) begin
      fillTo("simultaneous", points[p]);
      repeat (3) begin
         driveCycle(1'b1, 1'b1, nextRandom());
         checkState("simultaneous");
      end
      drainAll("simultaneous");
   end
endtask

task automatic testSyncClear();
   dmaFifoPkg::dataWord_t word;
   fillTo("syncClear", `FIFO_AE_THRESHOLD + 2);
   // clear with a write in the same cycle
   // the write is dropped
   syncReset_n = 1'b0;
   wrEn = 1'b1;
   dataIn = nextRandom();
   @(posedge clkin);
   refQueue.delete();
   @(negedge clkin);
   syncReset_n = 1'b1;
   wrEn = 1'b0;
   checkValue("syncClear", "empty", 1, dmaFifoPkg::dataWord_t'(empty));
   checkValue("syncClear", "almostEmpty", 1, dmaFifoPkg::dataWord_t'(almostEmpty));
   checkValue("syncClear", "full", 0, dmaFifoPkg::dataWord_t'(full));
   checkValue("syncClear", "almostFull", 0, dmaFifoPkg::dataWord_t'(almostFull));
   checkValue("syncClear", "dataOut", '0, dataOut);
   word = nextRandom();
   driveCycle(1'b1, 1'b0, word);
   checkValue("syncClear", "dataOut", word, dataOut);
   checkState("syncClear");
   drainAll("syncClear");
endtask

// write heavy first half and read heavy second half
task automatic testRandomTraffic();
   logic [31:0] rnd;
   logic        wr;
   logic        rd;
   for (int i = 0; i < RANDOM_CYCLES; i++) begin
      rnd = nextRandom();
      wr = (i < RANDOM_CYCLES / 2) ? (rnd[1:0] != 2'b00) : rnd[2];
      rd = (i < RANDOM_CYCLES / 2) ? rnd[3] : (rnd[5:4] != 2'b00);
      if (refQueue.size() == `FIFO_DEPTH) begin
         wr = 1'b0;
      end
      if (refQueue.size() == 0) begin
         rd = 1'b0;
      end
      driveCycle(wr, rd, nextRandom());
      checkState("randomTraffic");
   end
   drainAll("randomTraffic");
endtask

`endif

// ==== tb/tb_dmaFifo.sv ====
`default_nettype none

`include "dmaFifo_defs.svh"

module tb_dmaFifo;

   localparam int CLK_PERIOD = 100;
   localparam int RESET_CYCLES = 5;
   localparam int RANDOM_CYCLES = 400;
   localparam logic [31:0] LCG_SEED = 32'h36b1_53e3;

   // worst case cycle budget of each test
   localparam int FILL_DRAIN_CYCLES = 2 * `FIFO_DEPTH;
   localparam int SAME_CYCLES = 5 * (2 * `FIFO_DEPTH + 3);
   localparam int CLEAR_CYCLES = `FIFO_DEPTH + 4;
   localparam int TEST_CYCLES = RESET_CYCLES + 2 + FILL_DRAIN_CYCLES + SAME_CYCLES
                                + CLEAR_CYCLES + RANDOM_CYCLES + `FIFO_DEPTH;
   localparam int WATCHDOG_CYCLES = TEST_CYCLES + 100;

   logic                  clkin;
   logic                  reset_n;
   logic                  syncReset_n;
   logic                  wrEn;
   logic                  rdEn;
   dmaFifoPkg::dataWord_t dataIn;
   dmaFifoPkg::dataWord_t dataOut;
   logic                  empty;
   logic                  almostEmpty;
   logic                  full;
   logic                  almostFull;

   // reference model whose front is the word on dataOut
   dmaFifoPkg::dataWord_t refQueue[$];

   logic [31:0] lcgState;

   dmaFifo UUT (
      .clkin       (clkin),
      .reset_n     (reset_n),
      .syncReset_n (syncReset_n),
      .wrEn        (wrEn),
      .dataIn      (dataIn),
      .rdEn        (rdEn),
      .dataOut     (dataOut),
      .empty       (empty),
      .almostEmpty (almostEmpty),
      .full        (full),
      .almostFull  (almostFull)
   );

   `include "tbTasks.svh"

   // free running clock
   initial begin
      clkin = 1'b0;
      forever begin
         #(CLK_PERIOD / 2) clkin = ~clkin;
      end
   end

   // watchdog sized from the test budget
   initial begin
      #(CLK_PERIOD * WATCHDOG_CYCLES);
      $display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
      $display("Checks failed");
      $fatal(1, "watchdog expired");
   end

   // test sequence
   initial begin
      reset_n = 1'b0;
      syncReset_n = 1'b1;
      wrEn = 1'b0;
      rdEn = 1'b0;
      dataIn = '0;
      lcgState = LCG_SEED;

      repeat (RESET_CYCLES) @(posedge clkin);
      @(negedge clkin);
      // release between edges so the state is still the reset state here
      reset_n = 1'b1;

      testAfterReset();
      testFallThrough();
      testFillDrain();
      testSimultaneous();
      testSyncClear();
      testRandomTraffic();

      $display("All checks passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+rtl
+incdir+tb
rtl/dmaFifoPkg.sv
rtl/fifoControl.sv
rtl/fifoStorage.sv
rtl/dmaFifo.sv
tb/tb_dmaFifo.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the DMA FIFO testbench with Verilator.
# Run from the project root.

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=tb_dmaFifo

rm -rf "$BUILD_DIR" "$LOG_FILE"

if ! verilator --binary --timing -f verilog.f --top-module "$TOP" \
      -Mdir "$BUILD_DIR" -o simv; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/simv" > "$LOG_FILE" 2>&1
RUN_STATUS=$?
cat "$LOG_FILE"

if [ "$RUN_STATUS" -ne 0 ]; then
   echo "Simulation exited with status $RUN_STATUS"
   exit 1
fi

if grep -q "All checks passed" "$LOG_FILE"; then
   echo "PASS"
   exit 0
else
   echo "FAIL"
   exit 1
fi
